/* board_pkg.sv */
`default_nettype none

`include "tetris_macros.svh"

package board_pkg;

	// one board row, bit i is column i
	typedef logic [`BOARD_W-1:0] row_t;

	typedef logic [4:0] row_idx_t;   // 0..23
	typedef logic [3:0] col_idx_t;   // 0..9

	// one row of a piece, bit i at column offset i from pos_x
	typedef logic [3:0] piece_row_t;

	// what one piece row sees around itself
	typedef struct packed {
		logic land;          // cell below taken, or floor
		logic block_left;    // wall or cell on the left
		logic block_right;   // wall or cell on the right
		row_t cells;         // piece row shifted to pos_x
	} probe_t;

endpackage

`default_nettype wire

/* board_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tetris_macros.svh"

module board_store (
	input  logic                     clk,
	input  logic                     rst,
	input  tetris_pkg::state_t       state,
	input  board_pkg::row_idx_t      pos_y,
	input  board_pkg::probe_t [3:0]  probes,
	input  board_pkg::row_idx_t      row_sel,
	output board_pkg::row_t [3:0]    here_rows,
	output board_pkg::row_t [3:0]    below_rows,
	output board_pkg::row_t          row_bits,
	output logic [6:0]               score,
	output logic                     topped_out
);

	board_pkg::row_t     board [`BOARD_H];
	board_pkg::row_t     comp_img [`BOARD_H];   // board after row removal
	board_pkg::row_idx_t scan_row;
	board_pkg::row_idx_t wr_row;
	logic [5:0]          near_idx [5];          // pos_y .. pos_y+4

	always_comb begin
		for (int k = 0; k < 5; k++) begin
			near_idx[k] = {1'b0, pos_y} + 6'(k);
		end
	end

	// rows under the piece, floor reads as solid
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			here_rows[i]  = (near_idx[i] < 6'(`BOARD_H)) ? board[near_idx[i][4:0]] : '1;
			below_rows[i] = (near_idx[i+1] < 6'(`BOARD_H)) ? board[near_idx[i+1][4:0]] : '1;
		end
	end

	// ======================================================================
	// board array
	// ======================================================================
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int r = 0; r < `BOARD_H; r++) begin
				board[r] <= '0;
			end
		end else begin
			case (state)
				tetris_pkg::idle: begin
					for (int r = 0; r < `BOARD_H; r++) begin
						board[r] <= '0;     // held empty until start
					end
				end
				tetris_pkg::place: begin
					for (int i = 0; i < 4; i++) begin
						if (near_idx[i] < 6'(`BOARD_H)) begin
							board[near_idx[i][4:0]] <= board[near_idx[i][4:0]] | probes[i].cells;
						end
					end
				end
				tetris_pkg::new_piece: begin
					for (int r = 0; r < `BOARD_H; r++) begin
						board[r] <= comp_img[r];
					end
				end
				default: ;
			endcase
		end
	end

	// ======================================================================
	// row removal, one row per cycle from the floor up
	// ======================================================================
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int r = 0; r < `BOARD_H; r++) begin
				comp_img[r] <= '0;
			end
			scan_row <= 5'(`BOARD_H - 1);
			wr_row   <= 5'(`BOARD_H - 1);
			score    <= 7'd0;
		end else begin
			case (state)
				tetris_pkg::idle: begin
					for (int r = 0; r < `BOARD_H; r++) begin
						comp_img[r] <= '0;
					end
					score <= 7'd0;
				end
				tetris_pkg::place: begin
					for (int r = 0; r < `BOARD_H; r++) begin
						comp_img[r] <= '0;   // rows left above the survivors stay empty
					end
					scan_row <= 5'(`BOARD_H - 1);
					wr_row   <= 5'(`BOARD_H - 1);
				end
				tetris_pkg::clear: begin
					if (&board[scan_row]) begin
						score <= score + 7'd1;
					end else begin
						comp_img[wr_row] <= board[scan_row];
						wr_row           <= wr_row - 5'd1;
					end
					scan_row <= scan_row - 5'd1;
				end
				default: ;
			endcase
		end
	end

	// any cell left in a hidden row of the next board
	always_comb begin
		topped_out = 1'b0;
		for (int r = 0; r < `HIDDEN_ROWS; r++) begin
			topped_out = topped_out | (|comp_img[r]);
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			row_bits <= '0;
		end else if (row_sel < 5'(`BOARD_H)) begin
			row_bits <= board[row_sel];
		end else begin
			row_bits <= '0;
		end
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
board_pkg.sv
tetris_pkg.sv
piece_source.sv
row_probe.sv
board_store.sv
game_control.sv
tetris_core.sv
tetris_props.sv
tb_tetris.sv

/* game_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tetris_macros.svh"

module game_control (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     start,
	input  logic                     drop,
	input  logic                     left,
	input  logic                     right,
	input  logic                     rotate,
	input  board_pkg::probe_t [3:0]  probes,
	input  logic                     topped_out,
	input  logic [2:0]               shape,
	input  logic [1:0]               rotation,
	output tetris_pkg::state_t       state,
	output board_pkg::row_idx_t      pos_y,
	output board_pkg::col_idx_t      pos_x,
	output logic                     rotate_en,
	output tetris_pkg::status_t      status
);

	tetris_pkg::state_t next_state;
	logic [4:0]         clr_cnt;     // cycles left in clear
	logic               land_any;
	logic               left_free;
	logic               right_free;
	logic               in_fall;
	logic               do_left;
	logic               do_right;

	always_comb begin
		land_any   = 1'b0;
		left_free  = 1'b1;
		right_free = 1'b1;
		for (int i = 0; i < 4; i++) begin
			land_any   = land_any | probes[i].land;
			left_free  = left_free & ~probes[i].block_left;
			right_free = right_free & ~probes[i].block_right;
		end
	end

	// drop beats rotate beats left beats right
	assign in_fall   = (state == tetris_pkg::fall);
	assign rotate_en = in_fall && rotate && !drop;
	assign do_left   = in_fall && left && !drop && !rotate && left_free;
	assign do_right  = in_fall && right && !drop && !rotate && !left && right_free;

	// ======================================================================
	// state machine
	// ======================================================================
	always_comb begin
		next_state = state;
		case (state)
			tetris_pkg::idle:      if (start) next_state = tetris_pkg::new_piece;
			tetris_pkg::new_piece: next_state = topped_out ? tetris_pkg::over : tetris_pkg::fall;
			tetris_pkg::fall:      if (drop && land_any) next_state = tetris_pkg::place;
			tetris_pkg::place:     next_state = tetris_pkg::clear;
			tetris_pkg::clear:     if (clr_cnt == 5'd0) next_state = tetris_pkg::new_piece;
			default:               next_state = state;    // over holds until reset
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state   <= tetris_pkg::idle;
			clr_cnt <= 5'd0;
		end else begin
			state <= next_state;
			if (state == tetris_pkg::place) begin
				clr_cnt <= 5'(`BOARD_H - 1);
			end else if (state == tetris_pkg::clear) begin
				clr_cnt <= clr_cnt - 5'd1;
			end
		end
	end

	// piece position
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pos_x <= board_pkg::col_idx_t'(`SPAWN_X);
			pos_y <= '0;
		end else if (state == tetris_pkg::new_piece) begin
			pos_x <= board_pkg::col_idx_t'(`SPAWN_X);
			pos_y <= '0;
		end else if (in_fall && drop && !land_any) begin
			pos_y <= pos_y + 5'd1;
		end else if (do_left) begin
			pos_x <= pos_x - 4'd1;
		end else if (do_right) begin
			pos_x <= pos_x + 4'd1;
		end
	end

	always_comb begin
		case (state)
			tetris_pkg::idle: status.phase = tetris_pkg::phase_ready;
			tetris_pkg::over: status.phase = tetris_pkg::phase_over;
			default:          status.phase = tetris_pkg::phase_playing;
		endcase
		status.piece.shape    = shape;
		status.piece.rotation = rotation;
		status.piece.pos_x    = pos_x;
		status.piece.pos_y    = pos_y;
		status.fall           = in_fall;
	end

endmodule

`default_nettype wire

/* piece_source.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tetris_macros.svh"

module piece_source (
	input  logic                         clk,
	input  logic                         rst,
	input  tetris_pkg::state_t           state,
	input  logic                         rotate_en,
	output board_pkg::piece_row_t [3:0]  rows,
	output logic [2:0]                   shape,
	output logic [1:0]                   rotation
);

	logic [15:0] shape_word;    // row i in bits 4i+3..4i

	// shape lfsr, seed 3 walks 6 7 4 2 5 1 and back to 3
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			shape    <= 3'(`SHAPE_SEED);
			rotation <= 2'd0;
		end else if (state == tetris_pkg::new_piece) begin
			shape    <= {shape[1], shape[2] ^ shape[0], shape[1] ^ shape[0]};
			rotation <= 2'd0;
		end else if (rotate_en) begin
			rotation <= rotation + 2'd1;   // wraps after 3
		end
	end

	// ======================================================================
	// shape table, index {shape, rotation}
	// ======================================================================
	always_comb begin
		case ({shape, rotation})
			// I
			5'd4, 5'd6:   shape_word = 16'h000f;
			5'd5, 5'd7:   shape_word = 16'h1111;
			// S
			5'd8, 5'd10:  shape_word = 16'h0036;
			5'd9, 5'd11:  shape_word = 16'h0231;
			// Z
			5'd12, 5'd14: shape_word = 16'h0063;
			5'd13, 5'd15: shape_word = 16'h0132;
			// L
			5'd16:        shape_word = 16'h0074;
			5'd17:        shape_word = 16'h0223;
			5'd18:        shape_word = 16'h0017;
			5'd19:        shape_word = 16'h0311;
			// J
			5'd20:        shape_word = 16'h0071;
			5'd21:        shape_word = 16'h0322;
			5'd22:        shape_word = 16'h0047;
			5'd23:        shape_word = 16'h0113;
			// T
			5'd24:        shape_word = 16'h0027;
			5'd25:        shape_word = 16'h0131;
			5'd26:        shape_word = 16'h0072;
			5'd27:        shape_word = 16'h0232;
			// O, also shape 7 overflow
			default:      shape_word = 16'h0033;
		endcase
	end

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			rows[i] = shape_word[4*i +: 4];
		end
	end

endmodule

`default_nettype wire

/* row_probe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tetris_macros.svh"

module row_probe (
	input  board_pkg::piece_row_t piece_row,
	input  board_pkg::col_idx_t   pos_x,
	input  board_pkg::row_t       here_row,
	input  board_pkg::row_t       below_row,
	output board_pkg::probe_t     result
);

	board_pkg::row_t placed;

	// cells shifted past column 9 fall off
	assign placed = board_pkg::row_t'(piece_row) << pos_x;

	always_comb begin
		result.cells = placed;
		result.land  = |(placed & below_row);

		// left is toward column 0
		result.block_left  = placed[0] | (|((placed >> 1) & here_row));
		result.block_right = placed[`BOARD_W-1] | (|((placed << 1) & here_row));
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_tetris -o sim_tetris

# the sim exits non-zero on failure, the log search decides
./obj_dir/sim_tetris > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
	exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
	exit 1
fi
exit 0

/* tb_tetris.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tetris_macros.svh"

module tb_tetris;

	localparam logic [3:0] A_IDLE = 4'd0, A_START = 4'd1, A_LEFT = 4'd2, A_RIGHT = 4'd3;
	localparam logic [3:0] A_ROT = 4'd4, A_DROP = 4'd5, A_TOPOUT = 4'd6, A_DEAD = 4'd7;
	localparam logic [7:0] NONE = 8'hff;     // no table value to compare
	localparam int N_STEPS = 14;

	typedef struct packed {
		logic [3:0] act;
		logic [7:0] cnt;
		logic [7:0] exp;    // pos_x after a move, score after a drop
	} step_t;

	// T, O, L and S steered so that the bottom row fills
	localparam step_t steps [N_STEPS] = '{
		'{A_IDLE, 8'd1, NONE},   '{A_START, 8'd1, NONE},
		'{A_RIGHT, 8'd6, 8'd7},  '{A_LEFT, 8'd9, 8'd0},
		'{A_ROT, 8'd2, NONE},    '{A_DROP, 8'd1, 8'd0},
		'{A_LEFT, 8'd1, 8'd3},   '{A_DROP, 8'd1, 8'd0},
		'{A_RIGHT, 8'd5, 8'd7},  '{A_DROP, 8'd1, 8'd0},
		'{A_RIGHT, 8'd1, 8'd5},  '{A_DROP, 8'd1, 8'd1},
		'{A_TOPOUT, 8'd40, NONE}, '{A_DEAD, 8'd1, NONE}
	};

	logic clk, rst, start, drop, left, right, rotate;
	board_pkg::row_idx_t row_sel;
	tetris_pkg::status_t status;
	logic [6:0] score;
	board_pkg::row_t row_bits;

	// reference model state
	logic [9:0] m_board [`BOARD_H];
	logic [2:0] m_shape;
	logic [1:0] m_rot;
	int m_x, m_y, m_score, m_phase;

	tetris_core i_tetris_core (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.drop     (drop),
		.left     (left),
		.right    (right),
		.rotate   (rotate),
		.row_sel  (row_sel),
		.status   (status),
		.score    (score),
		.row_bits (row_bits)
	);

	always #50 clk = ~clk;

	// ======================================================================
	// reference model
	// ======================================================================
	function automatic logic [15:0] shape_word(input logic [2:0] s, input logic [1:0] r);
		case (s)
			3'd1: return r[0] ? 16'h1111 : 16'h000f;   // I
			3'd2: return r[0] ? 16'h0231 : 16'h0036;   // S
			3'd3: return r[0] ? 16'h0132 : 16'h0063;   // Z
			3'd4: return (r == 0) ? 16'h0074 : (r == 1) ? 16'h0223 : (r == 2) ? 16'h0017 : 16'h0311;
			3'd5: return (r == 0) ? 16'h0071 : (r == 1) ? 16'h0322 : (r == 2) ? 16'h0047 : 16'h0113;
			3'd6: return (r == 0) ? 16'h0027 : (r == 1) ? 16'h0131 : (r == 2) ? 16'h0072 : 16'h0232;
			default: return 16'h0033;                 // O
		endcase
	endfunction

	function automatic logic [9:0] cells(input int i);
		logic [15:0] w;
		logic [9:0] c;
		w = shape_word(m_shape, m_rot);
		c = {6'b0, w[4*i +: 4]};
		return c << m_x;   // past column 9 is lost
	endfunction

	function automatic logic [9:0] row_at(input int r);
		return (r < `BOARD_H) ? m_board[r] : 10'h3ff;   // floor is solid
	endfunction

	function automatic bit can_move(input bit to_left);
		logic [9:0] c, h;
		for (int i = 0; i < 4; i++) begin
			c = cells(i);
			h = row_at(m_y + i);
			if (to_left && (c[0] || ((c >> 1) & h) != 0)) return 1'b0;
			if (!to_left && (c[9] || ((c << 1) & h) != 0)) return 1'b0;
		end
		return 1'b1;
	endfunction

	function automatic bit lands();
		for (int i = 0; i < 4; i++) begin
			if ((cells(i) & row_at(m_y + i + 1)) != 0) return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic next_piece();
		m_shape = {m_shape[1], m_shape[2] ^ m_shape[0], m_shape[1] ^ m_shape[0]};
		m_rot   = 2'd0;
		m_x     = `SPAWN_X;
		m_y     = 0;
		for (int r = 0; r < `HIDDEN_ROWS; r++) begin
			if (m_board[r] != 0) m_phase = 2;
		end
	endtask

	task automatic lock_piece();
		logic [9:0] nb [`BOARD_H];
		int w;
		for (int i = 0; i < 4; i++) begin
			if (m_y + i < `BOARD_H) m_board[m_y + i] |= cells(i);
		end
		for (int r = 0; r < `BOARD_H; r++) nb[r] = '0;
		w = `BOARD_H - 1;
		for (int r = `BOARD_H - 1; r >= 0; r--) begin   // compact from the floor up
			if (&m_board[r]) begin
				m_score++;
			end else begin
				nb[w] = m_board[r];
				w--;
			end
		end
		for (int r = 0; r < `BOARD_H; r++) m_board[r] = nb[r];
		next_piece();
	endtask

	// ======================================================================
	// checks and DUT access
	// ======================================================================
	task automatic check(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("** Error %s: expected %0d, actual %0d", name, exp, act);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	task automatic check_piece(input string name);
		check({name, " phase"}, m_phase, int'(status.phase));
		check({name, " fall"}, (m_phase == 1) ? 1 : 0, int'(status.fall));
		check({name, " shape"}, int'(m_shape), int'(status.piece.shape));
		check({name, " rotation"}, int'(m_rot), int'(status.piece.rotation));
		check({name, " pos_x"}, m_x, int'(status.piece.pos_x));
		check({name, " pos_y"}, m_y, int'(status.piece.pos_y));
		check({name, " score"}, m_score, int'(score));
	endtask

	task automatic check_board(input string name);
		for (int r = 0; r < `BOARD_H; r++) begin
			@(posedge clk);
			row_sel <= 5'(r);
			@(posedge clk);
			@(negedge clk);
			check($sformatf("%s row %0d", name, r), int'(m_board[r]), int'(row_bits));
		end
	endtask

	task automatic pulse(input logic [3:0] act);
		@(posedge clk);
		case (act)
			A_START: start  <= 1'b1;
			A_LEFT:  left   <= 1'b1;
			A_RIGHT: right  <= 1'b1;
			A_ROT:   rotate <= 1'b1;
			default: drop   <= 1'b1;
		endcase
		@(posedge clk);
		{start, drop, left, right, rotate} <= 5'b0;
		@(negedge clk);
	endtask

	// wait for the lock sequence to end in fall or over
	task automatic wait_settle();
		int n;
		n = 0;
		while (!status.fall && status.phase != tetris_pkg::phase_over) begin
			@(negedge clk);
			n++;
			if (n > 100) begin
				$display("timed out waiting for the next piece to start falling");
				$display("Test failures found");
				$fatal(1);
			end
		end
	endtask

	task automatic drop_piece(input string name);
		int n;
		n = 0;
		while (1) begin
			pulse(A_DROP);
			if (lands()) break;
			m_y++;
			check_piece(name);
			n++;
			if (n > 30) begin
				$display("piece never landed in %s", name);
				$display("Test failures found");
				$fatal(1);
			end
		end
		lock_piece();
		wait_settle();
		check_piece(name);
		check_board(name);
	endtask

	initial begin
		string name;
		clk = 1'b0;
		rst = 1'b0;
		{start, drop, left, right, rotate} = 5'b0;
		row_sel = '0;
		for (int r = 0; r < `BOARD_H; r++) m_board[r] = '0;
		m_shape = 3'(`SHAPE_SEED);
		m_rot   = 2'd0;
		m_x     = `SPAWN_X;
		m_y     = 0;
		m_score = 0;
		m_phase = 0;
		repeat (5) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		check_piece("reset");
		check_board("reset");

		for (int s = 0; s < N_STEPS; s++) begin
			name = $sformatf("step %0d", s);
			case (steps[s].act)
				A_IDLE, A_DEAD: begin   // strobes must change nothing
					pulse(A_LEFT);
					pulse(A_ROT);
					pulse(A_DROP);
					pulse(A_RIGHT);
					if (steps[s].act == A_DEAD) begin
						pulse(A_START);   // over holds until reset
					end
					check_piece(name);
					check_board(name);
				end
				A_START: begin
					pulse(A_START);
					m_phase = 1;
					next_piece();
					wait_settle();
					check_piece(name);
				end
				A_DROP: drop_piece(name);
				A_TOPOUT: begin
					for (int p = 0; p < int'(steps[s].cnt) && m_phase != 2; p++) begin
						drop_piece(name);
					end
					check({name, " game over"}, 2, int'(status.phase));
				end
				default: begin
					for (int k = 0; k < int'(steps[s].cnt); k++) begin
						pulse(steps[s].act);
						if (steps[s].act == A_ROT) begin
							m_rot++;
						end else if (can_move(steps[s].act == A_LEFT)) begin
							m_x += (steps[s].act == A_LEFT) ? -1 : 1;
						end
						check_piece(name);
					end
				end
			endcase
			if (steps[s].exp != NONE) begin
				if (steps[s].act == A_DROP) begin
					check({name, " table score"}, int'(steps[s].exp), int'(score));
				end else begin
					check({name, " table pos_x"}, int'(steps[s].exp),
						int'(status.piece.pos_x));
				end
			end
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

/* tetris_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tetris_core (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  logic                 drop,
	input  logic                 left,
	input  logic                 right,
	input  logic                 rotate,
	input  board_pkg::row_idx_t  row_sel,
	output tetris_pkg::status_t  status,
	output logic [6:0]           score,
	output board_pkg::row_t      row_bits
);

	tetris_pkg::state_t          state;
	board_pkg::row_idx_t         pos_y;
	board_pkg::col_idx_t         pos_x;
	board_pkg::piece_row_t [3:0] piece_rows;
	board_pkg::row_t [3:0]       here_rows;
	board_pkg::row_t [3:0]       below_rows;
	board_pkg::probe_t [3:0]     probes;
	logic                        topped_out;
	logic                        rotate_en;
	logic [2:0]                  shape;
	logic [1:0]                  rotation;

	piece_source i_piece_source (
		.clk       (clk),
		.rst       (rst),
		.state     (state),
		.rotate_en (rotate_en),
		.rows      (piece_rows),
		.shape     (shape),
		.rotation  (rotation)
	);

	// one probe per piece row
	for (genvar i = 0; i < 4; i++) begin : g_probe
		row_probe i_row_probe (
			.piece_row (piece_rows[i]),
			.pos_x     (pos_x),
			.here_row  (here_rows[i]),
			.below_row (below_rows[i]),
			.result    (probes[i])
		);
	end

	board_store i_board_store (
		.clk        (clk),
		.rst        (rst),
		.state      (state),
		.pos_y      (pos_y),
		.probes     (probes),
		.row_sel    (row_sel),
		.here_rows  (here_rows),
		.below_rows (below_rows),
		.row_bits   (row_bits),
		.score      (score),
		.topped_out (topped_out)
	);

	game_control i_game_control (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.drop       (drop),
		.left       (left),
		.right      (right),
		.rotate     (rotate),
		.probes     (probes),
		.topped_out (topped_out),
		.shape      (shape),
		.rotation   (rotation),
		.state      (state),
		.pos_y      (pos_y),
		.pos_x      (pos_x),
		.rotate_en  (rotate_en),
		.status     (status)
	);

endmodule

`default_nettype wire

/* tetris_macros.svh */
`ifndef TETRIS_MACROS_SVH
`define TETRIS_MACROS_SVH

// ==========================================================================
// board geometry
// ==========================================================================

// bit 0 of a row is the leftmost column
`define BOARD_W 10

// row 0 is the top, row 23 sits on the floor
`define BOARD_H 24

// rows 0..3 lie above the visible field
`define HIDDEN_ROWS 4

// ==========================================================================
// piece entry
// ==========================================================================

// column of piece offset 0 when a new piece appears
`define SPAWN_X 4

// shape lfsr value out of reset, never zero
`define SHAPE_SEED 3

`endif

/* tetris_pkg.sv */
`default_nettype none

package tetris_pkg;

	// ======================================================================
	// engine states
	// ======================================================================
	typedef enum logic [2:0] {
		idle,
		new_piece,
		fall,
		place,
		clear,
		over
	} state_t;

	// coarse view of the game for the outside
	typedef enum logic [1:0] {
		phase_ready,
		phase_playing,
		phase_over
	} phase_t;

	typedef struct packed {
		logic [2:0]          shape;
		logic [1:0]          rotation;
		board_pkg::col_idx_t pos_x;
		board_pkg::row_idx_t pos_y;
	} piece_t;

	typedef struct packed {
		phase_t phase;
		piece_t piece;
		logic   fall;    // high only in the fall state
	} status_t;

endpackage

`default_nettype wire

/* tetris_props.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tetris_macros.svh"

module tetris_props (
	input logic                clk,
	input logic                rst,
	input tetris_pkg::state_t  state,
	input board_pkg::col_idx_t pos_x,
	input tetris_pkg::status_t status
);

	logic [5:0] clr_len;   // cycles spent in the last clear

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			clr_len <= '0;
		end else if (state == tetris_pkg::clear) begin
			clr_len <= clr_len + 6'd1;
		end else begin
			clr_len <= '0;
		end
	end

	a_pos_x_range: assert property (@(posedge clk) disable iff (!rst) pos_x <= 4'd9)
		else $error("pos_x left the board");

	a_clear_len: assert property (@(posedge clk) disable iff (!rst)
		(clr_len != 0 && state != tetris_pkg::clear) |-> clr_len == 6'(`BOARD_H))
		else $error("clear did not last one cycle per row");

	a_fall_in_reset: assert property (@(posedge clk) !rst |-> !status.fall)
		else $error("fall flag high during reset");

endmodule

bind game_control tetris_props i_tetris_props (
	.clk    (clk),
	.rst    (rst),
	.state  (state),
	.pos_x  (pos_x),
	.status (status)
);

`default_nettype wire
